// ==== Makefile ====
TOP := fp_mul_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "ALL TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== filelist.f ====
src/fp_types_pkg.sv
src/fp_mul_pkg.sv
src/fp_unpack.sv
src/booth_multiplier.sv
src/fp_normalize.sv
src/fp_round.sv
src/fp_mul_top.sv
testbench/fp_mul_sva.sv
testbench/fp_mul_tb.sv

// ==== src/booth_multiplier.sv ====
`timescale 1ns/1ps

module booth_multiplier import fp_types_pkg::*, fp_mul_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  unpack_s  stage_in,
    output product_s stage_out
);

    // two zero bits on top keep the unsigned multiplier positive
    logic [SIG_W+2:0]  y_ext;
    logic [PROD_W-1:0] x_ext;
    logic [PROD_W-1:0] prod_sum;

    // one partial product from a 3-bit booth window
    function automatic logic [PROD_W-1:0] booth_pp(
        input logic [2:0]        digit,
        input logic [PROD_W-1:0] mcand
    );
        case (digit)
            3'b001, 3'b010: begin
                return mcand;
            end
            3'b011: begin
                return mcand << 1;
            end
            3'b100: begin
                return -(mcand << 1);
            end
            3'b101, 3'b110: begin
                return -mcand;
            end
            default: begin
                return '0;
            end
        endcase
    endfunction

    assign y_ext = {2'b00, stage_in.sig_y, 1'b0};
    assign x_ext = {{(PROD_W - SIG_W){1'b0}}, stage_in.sig_x};

    // negative terms wrap mod 2^48, the true product always fits
    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < BOOTH_DIGITS; i++) begin
            prod_sum = prod_sum + (booth_pp(y_ext[2*i +: 3], x_ext) << (2 * i));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_out <= '0;
        end else begin
            stage_out.valid   <= stage_in.valid;
            stage_out.sign    <= stage_in.sign;
            stage_out.exp_sum <= stage_in.exp_sum;
            stage_out.product <= prod_sum;
            stage_out.special <= stage_in.special;
            stage_out.mode    <= stage_in.mode;
        end
    end

endmodule

// ==== src/fp_mul_pkg.sv ====
package fp_mul_pkg;

    import fp_types_pkg::*;

    // biased exponent sum, signed, with headroom both ways
    localparam int EXP_SUM_W = 10;

    // radix-4 digits for an unsigned 24-bit multiplier
    localparam int BOOTH_DIGITS = SIG_W / 2 + 1;

    // per-operand class
    typedef struct packed {
        logic zero;
        logic inf;
        logic nan;
    } fp_class_s;

    // outcome decided in stage 1
    typedef enum logic [1:0] {
        SP_NONE = 2'd0,
        SP_ZERO = 2'd1,
        SP_INF  = 2'd2,
        SP_NAN  = 2'd3
    } special_e;

    // stage 1 to stage 2
    typedef struct packed {
        logic                        valid;
        logic                        sign;
        logic signed [EXP_SUM_W-1:0] exp_sum;
        logic [SIG_W-1:0]            sig_x;
        logic [SIG_W-1:0]            sig_y;
        special_e                    special;
        round_mode_e                 mode;
    } unpack_s;

    // stage 2 to stage 3
    typedef struct packed {
        logic                        valid;
        logic                        sign;
        logic signed [EXP_SUM_W-1:0] exp_sum;
        logic [PROD_W-1:0]           product;
        special_e                    special;
        round_mode_e                 mode;
    } product_s;

    // stage 3 to stage 4
    // sig_norm is hidden bit, 23 fraction bits, guard, round, sticky
    typedef struct packed {
        logic                        valid;
        logic                        sign;
        logic signed [EXP_SUM_W-1:0] exp_adj;
        logic [NORM_W-1:0]           sig_norm;
        special_e                    special;
        round_mode_e                 mode;
    } norm_s;

endpackage

// ==== src/fp_mul_top.sv ====
`timescale 1ns/1ps

module fp_mul_top import fp_types_pkg::*, fp_mul_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  float32_t    fp_x,
    input  float32_t    fp_y,
    input  round_mode_e r_mode,
    output logic        out_valid,
    output float32_t    fp_z,
    output logic        ovrf,
    output logic        udrf
);

    unpack_s  s1_unpack;
    product_s s2_product;
    norm_s    s3_norm;

    fp_unpack u_unpack (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .fp_x      (fp_x),
        .fp_y      (fp_y),
        .r_mode    (r_mode),
        .stage_out (s1_unpack)
    );

    booth_multiplier u_booth (
        .clk       (clk),
        .arst_n    (arst_n),
        .stage_in  (s1_unpack),
        .stage_out (s2_product)
    );

    fp_normalize u_normalize (
        .clk       (clk),
        .arst_n    (arst_n),
        .stage_in  (s2_product),
        .stage_out (s3_norm)
    );

    fp_round u_round (
        .clk       (clk),
        .arst_n    (arst_n),
        .stage_in  (s3_norm),
        .out_valid (out_valid),
        .fp_z      (fp_z),
        .ovrf      (ovrf),
        .udrf      (udrf)
    );

endmodule

// ==== src/fp_normalize.sv ====
`timescale 1ns/1ps

module fp_normalize import fp_types_pkg::*, fp_mul_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  product_s stage_in,
    output norm_s    stage_out
);

    logic                        norm_n;
    logic [PROD_W-1:0]           prod_shift;
    logic [NORM_W-1:0]           sig_norm;
    logic signed [EXP_SUM_W-1:0] exp_adj;

    // product of two 1.x values is in [1,4)
    assign norm_n     = stage_in.product[PROD_W-1];
    assign prod_shift = norm_n ? stage_in.product : (stage_in.product << 1);

    // top 26 bits kept, the low 22 fold into sticky
    assign sig_norm = {prod_shift[PROD_W-1 -: NORM_W-1],
                       |prod_shift[PROD_W-NORM_W:0]};

    assign exp_adj = stage_in.exp_sum + EXP_SUM_W'(norm_n);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_out <= '0;
        end else begin
            stage_out.valid    <= stage_in.valid;
            stage_out.sign     <= stage_in.sign;
            stage_out.exp_adj  <= exp_adj;
            stage_out.sig_norm <= sig_norm;
            stage_out.special  <= stage_in.special;
            stage_out.mode     <= stage_in.mode;
        end
    end

endmodule

// ==== src/fp_round.sv ====
`timescale 1ns/1ps

module fp_round import fp_types_pkg::*, fp_mul_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  norm_s    stage_in,
    output logic     out_valid,
    output float32_t fp_z,
    output logic     ovrf,
    output logic     udrf
);

    logic [22:0]                 frac_trunc;
    logic                        lsb;
    logic                        guard;
    logic                        rnd_stk;
    logic                        round_inc;
    logic [23:0]                 frac_rnd;
    logic signed [EXP_SUM_W-1:0] exp_rnd;
    logic                        exp_ovf;
    logic                        exp_udf;
    logic                        ovf_to_inf;
    float32_t                    inf_word;
    float32_t                    z_next;
    logic                        ovf_next;
    logic                        udf_next;

    assign frac_trunc = stage_in.sig_norm[NORM_W-2 -: 23];
    assign lsb        = stage_in.sig_norm[3];
    assign guard      = stage_in.sig_norm[2];
    assign rnd_stk    = |stage_in.sig_norm[1:0];

    always_comb begin
        case (stage_in.mode)
            RM_RTZ:  round_inc = 1'b0;
            RM_RDN:  round_inc = stage_in.sign & (guard | rnd_stk);
            RM_RUP:  round_inc = ~stage_in.sign & (guard | rnd_stk);
            RM_RMM:  round_inc = guard;
            // ties to even also covers unused codes
            default: round_inc = guard & (rnd_stk | lsb);
        endcase
    end

    // carry out means the fraction wrapped to zero
    assign frac_rnd = {1'b0, frac_trunc} + 24'(round_inc);
    assign exp_rnd  = stage_in.exp_adj + EXP_SUM_W'(frac_rnd[23]);
    assign exp_ovf  = (exp_rnd >= EXP_MAX);
    assign exp_udf  = (exp_rnd <= 0);

    always_comb begin
        case (stage_in.mode)
            RM_RTZ:  ovf_to_inf = 1'b0;
            RM_RDN:  ovf_to_inf = stage_in.sign;
            RM_RUP:  ovf_to_inf = ~stage_in.sign;
            // both ties modes and unused codes
            default: ovf_to_inf = 1'b1;
        endcase
    end

    assign inf_word.bits = {stage_in.sign, 8'(EXP_MAX), 23'b0};

    always_comb begin
        ovf_next = 1'b0;
        udf_next = 1'b0;
        case (stage_in.special)
            SP_NAN:  z_next.bits = QNAN_WORD;
            SP_INF:  z_next = inf_word;
            SP_ZERO: z_next.bits = {stage_in.sign, 31'b0};
            default: begin
                if (exp_ovf) begin
                    ovf_next    = 1'b1;
                    z_next.bits = ovf_to_inf ? inf_word.bits
                                             : {stage_in.sign, MAX_FINITE_MAG};
                end else if (exp_udf) begin
                    // no subnormal output
                    udf_next    = 1'b1;
                    z_next.bits = {stage_in.sign, 31'b0};
                end else begin
                    z_next.f.sign = stage_in.sign;
                    z_next.f.exp  = exp_rnd[7:0];
                    z_next.f.frac = frac_rnd[22:0];
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            fp_z      <= '0;
            ovrf      <= 1'b0;
            udrf      <= 1'b0;
        end else begin
            out_valid <= stage_in.valid;
            fp_z      <= z_next;
            ovrf      <= stage_in.valid & ovf_next;
            udrf      <= stage_in.valid & udf_next;
        end
    end

endmodule

// ==== src/fp_types_pkg.sv ====
package fp_types_pkg;

    // binary32 layout
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;

    // significand widths through the datapath
    localparam int SIG_W  = 24;
    localparam int PROD_W = 48;
    localparam int NORM_W = 27;

    // canonical quiet nan
    localparam logic [31:0] QNAN_WORD      = 32'h7FC0_0000;
    // largest finite magnitude, sign excluded
    localparam logic [30:0] MAX_FINITE_MAG = 31'h7F7F_FFFF;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] frac;
    } float32_fields_s;

    // same word seen as raw bits or as fields
    typedef union packed {
        logic [31:0]     bits;
        float32_fields_s f;
    } float32_t;

    typedef enum logic [2:0] {
        RM_RNE = 3'd0,
        RM_RTZ = 3'd1,
        RM_RDN = 3'd2,
        RM_RUP = 3'd3,
        RM_RMM = 3'd4
    } round_mode_e;

endpackage

// ==== src/fp_unpack.sv ====
`timescale 1ns/1ps

module fp_unpack import fp_types_pkg::*, fp_mul_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  float32_t    fp_x,
    input  float32_t    fp_y,
    input  round_mode_e r_mode,
    output unpack_s     stage_out
);

    fp_class_s cls_x;
    fp_class_s cls_y;
    special_e  special;
    unpack_s   unpack_next;

    // subnormals land in zero, flush to zero
    function automatic fp_class_s classify(input float32_t v);
        fp_class_s c;
        c.zero = (v.f.exp == '0);
        c.inf  = (v.f.exp == 8'(EXP_MAX)) && (v.f.frac == '0);
        c.nan  = (v.f.exp == 8'(EXP_MAX)) && (v.f.frac != '0);
        return c;
    endfunction

    assign cls_x = classify(fp_x);
    assign cls_y = classify(fp_y);

    always_comb begin
        if (cls_x.nan || cls_y.nan ||
            (cls_x.inf && cls_y.zero) || (cls_y.inf && cls_x.zero)) begin
            special = SP_NAN;
        end else if (cls_x.inf || cls_y.inf) begin
            special = SP_INF;
        end else if (cls_x.zero || cls_y.zero) begin
            special = SP_ZERO;
        end else begin
            special = SP_NONE;
        end
    end

    always_comb begin
        unpack_next.valid   = in_valid;
        unpack_next.sign    = fp_x.f.sign ^ fp_y.f.sign;
        unpack_next.exp_sum = {2'b00, fp_x.f.exp} + {2'b00, fp_y.f.exp}
                              - EXP_SUM_W'(EXP_BIAS);
        unpack_next.special = special;
        unpack_next.mode    = r_mode;
        // multiplier gets nothing to chew on for specials
        if (special == SP_NONE) begin
            unpack_next.sig_x = {1'b1, fp_x.f.frac};
            unpack_next.sig_y = {1'b1, fp_y.f.frac};
        end else begin
            unpack_next.sig_x = '0;
            unpack_next.sig_y = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stage_out <= '0;
        end else begin
            stage_out <= unpack_next;
        end
    end

endmodule

// ==== testbench/fp_mul_sva.sv ====
`timescale 1ns/1ps

module fp_mul_sva import fp_types_pkg::*; (
    input logic     clk,
    input logic     arst_n,
    input logic     in_valid,
    input logic     out_valid,
    input float32_t fp_z,
    input logic     ovrf,
    input logic     udrf
);

    // four register stages from in_valid to out_valid
    latency_a: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, 4))
        else $error("out_valid is not in_valid delayed by four cycles");

    flags_excl_a: assert property (@(posedge clk) disable iff (!arst_n)
        !(ovrf && udrf))
        else $error("ovrf and udrf high together");

    flags_valid_a: assert property (@(posedge clk) disable iff (!arst_n)
        (ovrf || udrf) |-> out_valid)
        else $error("flag high without out_valid");

    nan_canon_a: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && fp_z.f.exp == 8'hFF && fp_z.f.frac != '0) |-> fp_z.bits == QNAN_WORD)
        else $error("nan result is not the canonical quiet nan");

endmodule

bind fp_mul_top fp_mul_sva sva_i (.*);

// ==== testbench/fp_mul_tb.sv ====
`timescale 1ns/1ps

module fp_mul_tb
    import fp_types_pkg::*;
();

    localparam int MAX_VEC   = 64;
    localparam int WORDS     = 6;
    localparam int DRAIN_MAX = 40;

    typedef struct packed {
        int          idx;
        logic [31:0] z;
        logic        ovrf;
        logic        udrf;
    } expect_s;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    float32_t    fp_x;
    float32_t    fp_y;
    round_mode_e r_mode;
    logic        out_valid;
    float32_t    fp_z;
    logic        ovrf;
    logic        udrf;

    logic [31:0] vec_mem [MAX_VEC*WORDS];
    expect_s     exp_q [$];
    int          errors;
    int          n_sent;
    int          n_checked;
    int          seed;

    fp_mul_top dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .fp_x      (fp_x),
        .fp_y      (fp_y),
        .r_mode    (r_mode),
        .out_valid (out_valid),
        .fp_z      (fp_z),
        .ovrf      (ovrf),
        .udrf      (udrf)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic check_result();
        expect_s e;
        e = exp_q.pop_front();
        assert (fp_z.bits == e.z) else begin
            errors++;
            $display("[ERROR] fp_z: got %h, expected %h (vector %0d)", fp_z.bits, e.z, e.idx);
        end
        assert (ovrf == e.ovrf) else begin
            errors++;
            $display("[ERROR] ovrf: got %h, expected %h (vector %0d)", ovrf, e.ovrf, e.idx);
        end
        assert (udrf == e.udrf) else begin
            errors++;
            $display("[ERROR] udrf: got %h, expected %h (vector %0d)", udrf, e.udrf, e.idx);
        end
        n_checked++;
    endtask

    // outputs settle after the rising edge, so look on the falling one
    always @(negedge clk) begin
        if (!arst_n) begin
            assert (!out_valid) else begin
                errors++;
                $display("out_valid was high while reset was asserted");
            end
        end else if (out_valid) begin
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("out_valid rose with no operation in flight");
            end
            if (exp_q.size() != 0) begin
                check_result();
            end
        end
    end

    initial begin
        int n_vec;
        int gap;
        int base;
        int wait_cycles;

        errors    = 0;
        n_sent    = 0;
        n_checked = 0;
        seed      = 31;
        arst_n    = 1'b0;
        in_valid  = 1'b0;
        fp_x      = '0;
        fp_y      = '0;
        r_mode    = RM_RNE;

        // mode word of an unused slot is never below 8
        for (int i = 0; i < MAX_VEC * WORDS; i++) begin
            vec_mem[i] = 32'hF000_0000 ^ 32'(i);
        end
        $readmemh("testbench/fp_mul_testdata.txt", vec_mem);
        n_vec = 0;
        while (n_vec < MAX_VEC && vec_mem[n_vec * WORDS + 2] < 32'd8) begin
            n_vec++;
        end
        assert (n_vec > 0) else begin
            errors++;
            $display("no test vectors were read from the data file");
        end

        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        for (int i = 0; i < n_vec; i++) begin
            base = i * WORDS;
            @(posedge clk);
            #1;
            in_valid  = 1'b1;
            fp_x.bits = vec_mem[base];
            fp_y.bits = vec_mem[base + 1];
            r_mode    = round_mode_e'(vec_mem[base + 2][2:0]);
            exp_q.push_back('{idx: i, z: vec_mem[base + 3],
                              ovrf: vec_mem[base + 4][0], udrf: vec_mem[base + 5][0]});
            n_sent++;
            // 0 gives back-to-back issue
            gap = int'($unsigned($random(seed)) % 3);
            if (gap > 0) begin
                @(posedge clk);
                #1;
                in_valid = 1'b0;
                repeat (gap - 1) @(posedge clk);
            end
        end
        @(posedge clk);
        #1;
        in_valid = 1'b0;

        wait_cycles = 0;
        while (n_checked < n_sent && wait_cycles < DRAIN_MAX) begin
            @(posedge clk);
            wait_cycles++;
        end
        assert (n_checked == n_sent) else begin
            errors++;
            $display("timed out with %0d results still missing", n_sent - n_checked);
        end
        // idle window to catch a stray out_valid
        repeat (4) @(negedge clk);

        $display("checked %0d of %0d results, %0d errors", n_checked, n_sent, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/fp_mul_testdata.txt ====
// columns: x y mode expected_z expected_ovrf expected_udrf, all hex
// mode 0 rne, 1 rtz, 2 rdn, 3 rup, 4 rmm, other codes act as rne
40400000 40400000 1 41100000 0 0
C0000000 40400000 0 C0C00000 0 0
3DCCCCCD 41200000 0 3F800000 0 0
3DCCCCCD 41200000 3 3F800001 0 0
3F800800 3F800800 0 3F801000 0 0
3F800800 3F800800 4 3F801001 0 0
BF800800 3F800800 2 BF801001 0 0
3FC00000 3F800001 0 3FC00002 0 0
3FC00000 3F800001 1 3FC00001 0 0
C0400000 3F800001 3 C0400001 0 0
3FC00000 3F800001 5 3FC00002 0 0
3F918E00 3FE12000 0 40000000 0 0
3F918E00 3FE12000 1 3FFFFFFF 0 0
3FFFFFFF 3F800001 3 40000001 0 0
00000000 40400000 0 00000000 0 0
00000001 C0000000 0 80000000 0 0
807FFFFF BF800000 3 00000000 0 0
7FC00000 3F800000 0 7FC00000 0 0
7F800000 00000000 0 7FC00000 0 0
7F800000 00000001 1 7FC00000 0 0
7F800000 C0000000 0 FF800000 0 0
FF800000 FF800000 2 7F800000 0 0
7F000000 40000000 0 7F800000 1 0
7F000000 40000000 1 7F7FFFFF 1 0
FF000000 40000000 2 FF800000 1 0
FF000000 40000000 3 FF7FFFFF 1 0
7F7FFFFF 3F800001 4 7F800000 1 0
00800000 3F000000 0 00000000 0 1
80800000 3F000000 3 80000000 0 1
